// ==== rtl/vcore_pkg.sv ====
`default_nettype none

package vcore_pkg;

    // byte address on the external memory port
    typedef logic [26:0] addr_t;

    // one vector register or one memory line
    typedef logic [127:0] line_t;

    typedef logic [3:0] lane_mask_t;
    typedef logic [3:0] reg_idx_t;

    // all-zero word decodes as halt, so empty memory stops the core
    typedef enum logic [5:0] {
        HALT = 6'h00,
        VADD = 6'h01,
        VSUB = 6'h02,
        VAND = 6'h03,
        VOR  = 6'h04,
        VXOR = 6'h05,
        VLI  = 6'h06,
        VLD  = 6'h07,
        VST  = 6'h08,
        BEQZ = 6'h09,
        JMP  = 6'h0a
    } opcode_e;

    // raw opcode field, decode maps unknown values to HALT
    typedef struct packed {
        logic [5:0]        opcode;
        reg_idx_t          rd;
        reg_idx_t          rs1;
        reg_idx_t          rs2;
        lane_mask_t        mask;
        logic signed [9:0] imm;
    } instr_t;

    typedef struct packed {
        addr_t       addr;
        logic        we;
        line_t       wdata;
        logic [15:0] wstrb;
    } bus_req_t;

    typedef struct packed {
        opcode_e           opcode;
        reg_idx_t          rd;
        lane_mask_t        mask;
        line_t             op1;
        line_t             op2;
        logic signed [9:0] imm;
        addr_t             pc;
    } uop_t;

    typedef struct packed {
        reg_idx_t   rd;
        lane_mask_t mask;
        line_t      data;
    } wb_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter vcore_pkg::addr_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               retire,
    input  logic               redirect,
    input  vcore_pkg::addr_t   target,
    input  logic               halted,
    output vcore_pkg::bus_req_t fetch_req,
    output logic               fetch_req_valid,
    input  logic               fetch_req_ready,
    input  logic               fetch_rsp_valid,
    input  vcore_pkg::line_t   rsp_data,
    output logic               inst_valid,
    output vcore_pkg::instr_t  inst,
    output vcore_pkg::addr_t   inst_pc,
    output logic [15:0]        pc
);
    import vcore_pkg::*;

    typedef enum logic [1:0] {F_LAUNCH, F_REQ, F_WAIT, F_EXEC} fetch_state_e;

    fetch_state_e state;
    addr_t        pc_q;
    logic         req_valid;

    // line read, word picked out of the response later
    assign fetch_req.addr  = {pc_q[26:4], 4'b0000};
    assign fetch_req.we    = 1'b0;
    assign fetch_req.wdata = '0;
    assign fetch_req.wstrb = '0;
    assign fetch_req_valid = req_valid;
    assign pc              = pc_q[15:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= F_LAUNCH;
            pc_q       <= RESET_PC;
            req_valid  <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            case (state)
                F_LAUNCH: begin
                    if (!halted) begin
                        req_valid <= 1'b1;
                        state     <= F_REQ;
                    end
                end
                F_REQ: begin
                    if (fetch_req_ready) begin
                        req_valid <= 1'b0;
                        state     <= F_WAIT;
                    end
                end
                F_WAIT: begin
                    if (fetch_rsp_valid) begin
                        inst_valid <= 1'b1;
                        state      <= F_EXEC;
                    end
                end
                F_EXEC: begin
                    // next fetch goes out right after retire
                    if (retire && !halted) begin
                        pc_q      <= redirect ? target : pc_q + addr_t'(4);
                        req_valid <= 1'b1;
                        state     <= F_REQ;
                    end
                end
                default: state <= F_LAUNCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_WAIT && fetch_rsp_valid) begin
            inst    <= instr_t'(rsp_data[pc_q[3:2]*32 +: 32]);
            inst_pc <= pc_q;
        end
    end

    // stalled request must not move until the arbiter takes it
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req_valid && !fetch_req_ready |=> fetch_req_valid && $stable(fetch_req));

endmodule

`default_nettype wire

// ==== rtl/decode_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  vcore_pkg::instr_t inst,
    input  vcore_pkg::addr_t  inst_pc,
    input  logic              wb_valid,
    input  vcore_pkg::wb_t    wb,
    output logic              uop_valid,
    output vcore_pkg::uop_t   uop
);
    import vcore_pkg::*;

    localparam int NUM_REGS  = 16;
    localparam int NUM_LANES = 4;

    line_t   regs [NUM_REGS];
    opcode_e dec_op;

    // unknown encodings fall through to halt
    always_comb begin
        case (inst.opcode)
            VADD, VSUB, VAND, VOR, VXOR,
            VLI, VLD, VST, BEQZ, JMP: dec_op = opcode_e'(inst.opcode);
            default:                  dec_op = HALT;
        endcase
    end

    // register file, lane-masked writeback
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wb_valid) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (wb.mask[l]) begin
                    regs[wb.rd][l*32 +: 32] <= wb.data[l*32 +: 32];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
        end else begin
            uop_valid <= inst_valid;
        end
    end

    // operands read once per instruction
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            uop.opcode <= dec_op;
            uop.rd     <= inst.rd;
            uop.mask   <= inst.mask;
            uop.op1    <= regs[inst.rs1];
            uop.op2    <= regs[inst.rs2];
            uop.imm    <= inst.imm;
            uop.pc     <= inst_pc;
        end
    end

    // nothing else is in flight while decode issues
    a_no_wb_on_issue: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> !wb_valid);

endmodule

`default_nettype wire

// ==== rtl/vector_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_alu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  uop_valid,
    input  vcore_pkg::uop_t       uop,
    output logic                  wb_valid,
    output vcore_pkg::wb_t        wb,
    output logic                  mem_start,
    output vcore_pkg::addr_t      mem_addr,
    output logic                  mem_we,
    output vcore_pkg::line_t      mem_data,
    output vcore_pkg::lane_mask_t mem_mask,
    output vcore_pkg::reg_idx_t   mem_rd,
    output logic                  retire,
    output logic                  redirect,
    output vcore_pkg::addr_t      target,
    output logic                  halted
);
    import vcore_pkg::*;

    line_t lane_res;
    addr_t imm_sext;
    addr_t line_addr;
    logic  is_alu;
    logic  is_mem;
    logic  is_ctl;
    logic  is_halt;
    logic  taken;

    assign imm_sext  = {{17{uop.imm[9]}}, uop.imm};
    // imm counts 16-byte lines here
    assign line_addr = uop.op1[26:0] + (imm_sext << 4);
    assign taken     = (uop.opcode == JMP) || (uop.op1[31:0] == 32'd0);

    // per-lane ops, wrapping 32-bit
    always_comb begin
        lane_res = '0;
        for (int l = 0; l < 4; l++) begin
            case (uop.opcode)
                VADD: lane_res[l*32 +: 32] = uop.op1[l*32 +: 32] + uop.op2[l*32 +: 32];
                VSUB: lane_res[l*32 +: 32] = uop.op1[l*32 +: 32] - uop.op2[l*32 +: 32];
                VAND: lane_res[l*32 +: 32] = uop.op1[l*32 +: 32] & uop.op2[l*32 +: 32];
                VOR:  lane_res[l*32 +: 32] = uop.op1[l*32 +: 32] | uop.op2[l*32 +: 32];
                VXOR: lane_res[l*32 +: 32] = uop.op1[l*32 +: 32] ^ uop.op2[l*32 +: 32];
                VLI:  lane_res[l*32 +: 32] = {{22{uop.imm[9]}}, uop.imm};
                default: lane_res[l*32 +: 32] = 32'd0;
            endcase
        end
    end

    always_comb begin
        is_alu  = 1'b0;
        is_mem  = 1'b0;
        is_ctl  = 1'b0;
        is_halt = 1'b0;
        case (uop.opcode)
            VADD, VSUB, VAND, VOR, VXOR, VLI: is_alu = 1'b1;
            VLD, VST:                         is_mem = 1'b1;
            BEQZ, JMP:                        is_ctl = 1'b1;
            default:                          is_halt = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid  <= 1'b0;
            mem_start <= 1'b0;
            retire    <= 1'b0;
            redirect  <= 1'b0;
            halted    <= 1'b0;
        end else begin
            wb_valid  <= uop_valid && is_alu;
            mem_start <= uop_valid && is_mem;
            retire    <= uop_valid && is_ctl;
            redirect  <= uop_valid && is_ctl && taken;
            // sticky until reset
            halted    <= halted || (uop_valid && is_halt);
        end
    end

    always_ff @(posedge clk) begin
        if (uop_valid) begin
            wb.rd    <= uop.rd;
            wb.mask  <= uop.mask;
            wb.data  <= lane_res;
            mem_addr <= {line_addr[26:4], 4'b0000};
            mem_we   <= (uop.opcode == VST);
            mem_data <= uop.op2;
            mem_mask <= uop.mask;
            mem_rd   <= uop.rd;
            target   <= uop.pc + (imm_sext << 2);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_start,
    input  vcore_pkg::addr_t      mem_addr,
    input  logic                  mem_we,
    input  vcore_pkg::line_t      mem_data,
    input  vcore_pkg::lane_mask_t mem_mask,
    input  vcore_pkg::reg_idx_t   mem_rd,
    output vcore_pkg::bus_req_t   lsu_req,
    output logic                  lsu_req_valid,
    input  logic                  lsu_req_ready,
    input  logic                  lsu_rsp_valid,
    input  vcore_pkg::line_t      rsp_data,
    output logic                  wb_valid,
    output vcore_pkg::wb_t        wb,
    output logic                  retire
);
    import vcore_pkg::*;

    bus_req_t    req_q;
    reg_idx_t    rd_q;
    lane_mask_t  mask_q;
    logic        busy;
    logic        req_valid;
    logic [15:0] lane_strb;

    // four byte enables per lane
    assign lane_strb = {{4{mem_mask[3]}}, {4{mem_mask[2]}}, {4{mem_mask[1]}}, {4{mem_mask[0]}}};

    assign lsu_req       = req_q;
    assign lsu_req_valid = req_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            req_valid <= 1'b0;
            wb_valid  <= 1'b0;
            retire    <= 1'b0;
        end else begin
            wb_valid <= 1'b0;
            retire   <= 1'b0;
            if (mem_start) begin
                busy      <= 1'b1;
                req_valid <= 1'b1;
            end else if (req_valid && lsu_req_ready) begin
                req_valid <= 1'b0;
            end
            // store ack retires, load data goes to writeback
            if (busy && lsu_rsp_valid) begin
                busy     <= 1'b0;
                retire   <= req_q.we;
                wb_valid <= !req_q.we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_start) begin
            req_q.addr  <= mem_addr;
            req_q.we    <= mem_we;
            req_q.wdata <= mem_data;
            req_q.wstrb <= mem_we ? lane_strb : 16'h0000;
            rd_q        <= mem_rd;
            mask_q      <= mem_mask;
        end
        if (busy && lsu_rsp_valid) begin
            wb.rd   <= rd_q;
            wb.mask <= mask_q;
            wb.data <= rsp_data;
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        mem_start |-> !busy);

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
    parameter bit HI_PRIO_LSU = 1'b1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  vcore_pkg::bus_req_t fetch_req,
    input  logic                fetch_req_valid,
    output logic                fetch_req_ready,
    input  vcore_pkg::bus_req_t lsu_req,
    input  logic                lsu_req_valid,
    output logic                lsu_req_ready,
    output vcore_pkg::bus_req_t bus_req,
    output logic                bus_req_valid,
    input  logic                bus_req_ready,
    input  logic                bus_rsp_valid,
    output logic                fetch_rsp_valid,
    output logic                lsu_rsp_valid
);

    // HOLD keeps the owner while the port stalls, WAIT until the response
    typedef enum logic [1:0] {ARB_IDLE, ARB_HOLD, ARB_WAIT} arb_state_e;

    arb_state_e state;
    logic       owner_lsu;
    logic       pick_lsu;
    logic       cur_lsu;
    logic       port_open;

    assign pick_lsu  = lsu_req_valid && (HI_PRIO_LSU || !fetch_req_valid);
    assign cur_lsu   = (state == ARB_IDLE) ? pick_lsu : owner_lsu;
    assign port_open = (state != ARB_WAIT);

    assign bus_req         = cur_lsu ? lsu_req : fetch_req;
    assign bus_req_valid   = port_open && (cur_lsu ? lsu_req_valid : fetch_req_valid);
    assign lsu_req_ready   = port_open && cur_lsu && bus_req_ready;
    assign fetch_req_ready = port_open && !cur_lsu && bus_req_ready;

    // response goes back to whoever holds the grant
    assign lsu_rsp_valid   = bus_rsp_valid && (state == ARB_WAIT) && owner_lsu;
    assign fetch_rsp_valid = bus_rsp_valid && (state == ARB_WAIT) && !owner_lsu;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ARB_IDLE;
            owner_lsu <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (bus_req_valid) begin
                        owner_lsu <= pick_lsu;
                        state     <= bus_req_ready ? ARB_WAIT : ARB_HOLD;
                    end
                end
                ARB_HOLD: begin
                    if (bus_req_ready) begin
                        state <= ARB_WAIT;
                    end
                end
                ARB_WAIT: begin
                    if (bus_rsp_valid) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // granted master keeps its request up and unchanged while the port stalls
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        state == ARB_HOLD |-> bus_req_valid && $stable(bus_req));

    // memory answers only what it accepted earlier
    a_rsp_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp_valid |-> state == ARB_WAIT);

endmodule

`default_nettype wire

// ==== rtl/vcore_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vcore_top #(
    parameter vcore_pkg::addr_t RESET_PC    = '0,
    parameter bit               HI_PRIO_LSU = 1'b1
) (
    input  logic                clk,
    input  logic                rst_n,
    output vcore_pkg::bus_req_t bus_req,
    output logic                bus_req_valid,
    input  logic                bus_req_ready,
    input  logic                bus_rsp_valid,
    input  vcore_pkg::line_t    bus_rsp_data,
    output logic                halted,
    output logic [15:0]         pc
);
    import vcore_pkg::*;

    bus_req_t   fetch_req, lsu_req;
    logic       fetch_req_valid, fetch_req_ready, fetch_rsp_valid;
    logic       lsu_req_valid, lsu_req_ready, lsu_rsp_valid;
    logic       inst_valid, uop_valid;
    instr_t     inst;
    addr_t      inst_pc;
    uop_t       uop;
    logic       alu_wb_valid, lsu_wb_valid, wb_valid;
    wb_t        alu_wb, lsu_wb, wb;
    logic       mem_start, mem_we;
    addr_t      mem_addr, target;
    line_t      mem_data;
    lane_mask_t mem_mask;
    reg_idx_t   mem_rd;
    logic       alu_retire, lsu_retire, retire, redirect;

    // one instruction in flight, so at most one source is active
    assign wb_valid = alu_wb_valid | lsu_wb_valid;
    assign wb       = lsu_wb_valid ? lsu_wb : alu_wb;
    assign retire   = alu_retire | lsu_retire | wb_valid;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk, .rst_n, .retire, .redirect, .target, .halted,
        .fetch_req, .fetch_req_valid, .fetch_req_ready, .fetch_rsp_valid,
        .rsp_data(bus_rsp_data), .inst_valid, .inst, .inst_pc, .pc
    );

    decode_regfile u_decode (
        .clk, .rst_n, .inst_valid, .inst, .inst_pc, .wb_valid, .wb, .uop_valid, .uop
    );

    vector_alu u_alu (
        .clk, .rst_n, .uop_valid, .uop, .wb_valid(alu_wb_valid), .wb(alu_wb),
        .mem_start, .mem_addr, .mem_we, .mem_data, .mem_mask, .mem_rd,
        .retire(alu_retire), .redirect, .target, .halted
    );

    load_store_unit u_lsu (
        .clk, .rst_n, .mem_start, .mem_addr, .mem_we, .mem_data, .mem_mask, .mem_rd,
        .lsu_req, .lsu_req_valid, .lsu_req_ready, .lsu_rsp_valid,
        .rsp_data(bus_rsp_data), .wb_valid(lsu_wb_valid), .wb(lsu_wb), .retire(lsu_retire)
    );

    mem_arbiter #(.HI_PRIO_LSU(HI_PRIO_LSU)) u_arb (
        .clk, .rst_n, .fetch_req, .fetch_req_valid, .fetch_req_ready,
        .lsu_req, .lsu_req_valid, .lsu_req_ready, .bus_req, .bus_req_valid,
        .bus_req_ready, .bus_rsp_valid, .fetch_rsp_valid, .lsu_rsp_valid
    );

endmodule

`default_nettype wire

// ==== verification/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
    parameter int MEM_LINES = 512
) (
    input  logic                clk,
    input  logic                rst_n,
    input  vcore_pkg::bus_req_t bus_req,
    input  logic                bus_req_valid,
    output logic                bus_req_ready,
    output logic                bus_rsp_valid,
    output vcore_pkg::line_t    bus_rsp_data
);
    import vcore_pkg::*;

    line_t       mem [MEM_LINES];
    line_t       rd_line;
    bus_req_t    xfer_req;
    bus_req_t    held_req;
    logic        live;
    logic        xfer;
    logic        held;
    logic        pending;
    logic        stall_drawn;
    int unsigned rsp_wait;
    int unsigned stall_left;
    int unsigned draw;
    int          idx;
    int          unstable_count;

    initial begin
        live          = 1'b0;
        bus_req_ready = 1'b0;
        bus_rsp_valid = 1'b0;
        bus_rsp_data  = '0;
    end

    task automatic load_line(input int line_idx, input line_t data);
        mem[line_idx] = data;
    endtask

    // sample the DUT side on the rising edge
    always @(posedge clk) begin
        live <= rst_n;
        if (!rst_n) begin
            xfer           <= 1'b0;
            held           <= 1'b0;
            unstable_count <= 0;
        end else begin
            xfer     <= bus_req_valid && bus_req_ready;
            xfer_req <= bus_req;
            held     <= bus_req_valid && !bus_req_ready;
            held_req <= bus_req;
            // stalled request has to come back unchanged
            if (held && (!bus_req_valid || bus_req != held_req)) begin
                unstable_count <= unstable_count + 1;
            end
        end
    end

    // drive ready and response on the falling edge
    always @(negedge clk) begin
        if (!live) begin
            bus_req_ready <= 1'b1;
            bus_rsp_valid <= 1'b0;
            bus_rsp_data  <= '0;
            pending       <= 1'b0;
            stall_drawn   <= 1'b0;
            rsp_wait      <= 0;
            stall_left    <= 0;
        end else begin
            bus_rsp_valid <= 1'b0;
            if (xfer) begin
                // 512 lines, so address bits 12:4 pick the line
                idx = int'(xfer_req.addr[12:4]);
                if (xfer_req.we) begin
                    for (int b = 0; b < 16; b++) begin
                        if (xfer_req.wstrb[b]) begin
                            mem[idx][b*8 +: 8] = xfer_req.wdata[b*8 +: 8];
                        end
                    end
                end
                draw = $urandom % 4;
                if (draw == 0) begin
                    bus_rsp_valid <= 1'b1;
                    bus_rsp_data  <= mem[idx];
                end else begin
                    pending  <= 1'b1;
                    rsp_wait <= draw - 1;
                    rd_line  <= mem[idx];
                end
                stall_drawn <= 1'b0;
            end else if (pending) begin
                if (rsp_wait == 0) begin
                    bus_rsp_valid <= 1'b1;
                    bus_rsp_data  <= rd_line;
                    pending       <= 1'b0;
                end else begin
                    rsp_wait <= rsp_wait - 1;
                end
            end
            // each new request sees ready low for 0 to 3 cycles
            if (stall_left != 0) begin
                stall_left    <= stall_left - 1;
                bus_req_ready <= (stall_left == 1);
            end else if (bus_req_valid && !stall_drawn && !xfer) begin
                draw = $urandom % 4;
                bus_req_ready <= (draw == 0);
                stall_left    <= draw;
                stall_drawn   <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_vcore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vcore;
    import vcore_pkg::*;

    localparam int MEM_LINES  = 512;
    localparam int DATA_LINE  = 64;
    localparam int HALT_LIMIT = 2000;
    localparam int STEP_LIMIT = 1000;

    logic        clk;
    logic        rst_n;
    bus_req_t    bus_req;
    logic        bus_req_valid;
    logic        bus_req_ready;
    logic        bus_rsp_valid;
    line_t       bus_rsp_data;
    logic        halted;
    logic [15:0] pc;

    logic [31:0] prog [$];
    line_t       exp_mem [MEM_LINES];
    logic [31:0] exp_pc;
    int          tests_passed;
    int          tests_failed;

    vcore_top DUT (
        .clk, .rst_n, .bus_req, .bus_req_valid, .bus_req_ready,
        .bus_rsp_valid, .bus_rsp_data, .halted, .pc
    );

    mem_model #(.MEM_LINES(MEM_LINES)) u_mem (
        .clk, .rst_n, .bus_req, .bus_req_valid, .bus_req_ready,
        .bus_rsp_valid, .bus_rsp_data
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // opcode, rd, rs1, rs2, mask, imm from bit 31 down
    function automatic logic [31:0] encode(input opcode_e op, input int rd, input int rs1,
                                           input int rs2, input int mask, input int imm);
        return {6'(op), 4'(rd), 4'(rs1), 4'(rs2), 4'(mask), 10'(imm)};
    endfunction

    task automatic emit(input opcode_e op, input int rd, input int rs1, input int rs2,
                        input int mask, input int imm);
        prog.push_back(encode(op, rd, rs1, rs2, mask, imm));
    endtask

    function automatic line_t pattern_line(input int line_idx);
        logic [31:0] a;
        a = 32'(line_idx);
        return {a ^ 32'hc3a5_0000, a * 32'h0101_0101, ~a, {a[15:0], 16'h5a5a}};
    endfunction

    // program from line 0, zero up to the data area, pattern above it
    task automatic load_memory();
        line_t img;
        for (int i = 0; i < MEM_LINES; i++) begin
            img = (i < DATA_LINE) ? '0 : pattern_line(i);
            for (int w = 0; w < 4; w++) begin
                if (i*4 + w < prog.size()) begin
                    img[w*32 +: 32] = prog[i*4 + w];
                end
            end
            exp_mem[i] = img;
            u_mem.load_line(i, img);
        end
    endtask

    // instruction level model, one instruction per step
    task automatic predict_results();
        line_t       r [16];
        line_t       src1;
        line_t       src2;
        logic [31:0] p;
        logic [31:0] p_next;
        logic [31:0] word;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] res;
        logic [5:0]  op;
        logic [3:0]  rd;
        logic [3:0]  mask;
        logic        running;
        int          steps;

        for (int i = 0; i < 16; i++) begin
            r[i] = '0;
        end
        p       = 0;
        running = 1'b1;
        steps   = 0;
        while (running && steps < STEP_LIMIT) begin
            word   = exp_mem[p[12:4]][p[3:2]*32 +: 32];
            op     = word[31:26];
            rd     = word[25:22];
            src1   = r[word[21:18]];
            src2   = r[word[17:14]];
            mask   = word[13:10];
            imm    = {{22{word[9]}}, word[9:0]};
            addr   = (src1[31:0] + (imm << 4)) & ~32'hf;
            p_next = p + 4;
            steps++;
            case (op)
                VADD, VSUB, VAND, VOR, VXOR, VLI: begin
                    for (int l = 0; l < 4; l++) begin
                        case (op)
                            VADD:    res = src1[l*32 +: 32] + src2[l*32 +: 32];
                            VSUB:    res = src1[l*32 +: 32] - src2[l*32 +: 32];
                            VAND:    res = src1[l*32 +: 32] & src2[l*32 +: 32];
                            VOR:     res = src1[l*32 +: 32] | src2[l*32 +: 32];
                            VXOR:    res = src1[l*32 +: 32] ^ src2[l*32 +: 32];
                            default: res = imm;
                        endcase
                        if (mask[l]) begin
                            r[rd][l*32 +: 32] = res;
                        end
                    end
                end
                VLD: begin
                    for (int l = 0; l < 4; l++) begin
                        if (mask[l]) begin
                            r[rd][l*32 +: 32] = exp_mem[addr[12:4]][l*32 +: 32];
                        end
                    end
                end
                VST: begin
                    for (int l = 0; l < 4; l++) begin
                        if (mask[l]) begin
                            exp_mem[addr[12:4]][l*32 +: 32] = src2[l*32 +: 32];
                        end
                    end
                end
                BEQZ: begin
                    if (src1[31:0] == 32'd0) begin
                        p_next = p + (imm << 2);
                    end
                end
                JMP:     p_next = p + (imm << 2);
                default: running = 1'b0;
            endcase
            if (running) begin
                p = p_next;
            end
        end
        exp_pc = p;
    endtask

    task automatic run_program(input string name);
        line_t got;
        int    cycles;
        int    errors;

        errors = 0;
        @(negedge clk);
        rst_n = 1'b0;
        load_memory();
        predict_results();
        repeat (3) @(negedge clk);
        rst_n  = 1'b1;
        cycles = 0;
        while (!halted && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("%s: the core did not halt within %0d cycles", name, HALT_LIMIT);
            errors++;
        end else begin
            for (int i = 0; i < MEM_LINES; i++) begin
                got = u_mem.mem[i];
                assert (got === exp_mem[i]) else begin
                    $display("** Error [%0t] %s: line %0d is %h, expected %h",
                             $time, name, i, got, exp_mem[i]);
                    errors++;
                end
            end
            assert (pc === exp_pc[15:0]) else begin
                $display("** Error [%0t] %s: halted at pc %h, expected %h",
                         $time, name, pc, exp_pc[15:0]);
                errors++;
            end
        end
        assert (u_mem.unstable_count == 0) else begin
            $display("** Error [%0t] %s: %0d requests changed while stalled",
                     $time, name, u_mem.unstable_count);
            errors++;
        end
        if (errors == 0) begin
            tests_passed++;
            $display("%s: ok after %0d cycles", name, cycles);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors);
        end
    endtask

    task automatic lane_arith_test();
        prog.delete();
        emit(VLI, 1, 0, 0, 4'b1111, 300);
        emit(VLI, 1, 0, 0, 4'b0010, -5);
        emit(VLI, 1, 0, 0, 4'b0100, 511);
        emit(VLI, 1, 0, 0, 4'b1000, -512);
        emit(VLI, 2, 0, 0, 4'b1111, -7);
        emit(VLI, 2, 0, 0, 4'b0001, 100);
        emit(VADD, 3, 1, 2, 4'b1111, 0);
        emit(VSUB, 4, 1, 2, 4'b1111, 0);
        emit(VAND, 5, 1, 2, 4'b1111, 0);
        emit(VOR, 6, 1, 2, 4'b1111, 0);
        emit(VXOR, 7, 1, 2, 4'b1111, 0);
        for (int k = 0; k < 5; k++) begin
            emit(VST, 0, 0, 3 + k, 4'b1111, 80 + k);
        end
        emit(HALT, 0, 0, 0, 0, 0);
        run_program("lane_arith");
    endtask

    task automatic lane_mask_test();
        prog.delete();
        emit(VLI, 1, 0, 0, 4'b1111, 77);
        emit(VLI, 2, 0, 0, 4'b1111, 5);
        emit(VADD, 1, 1, 2, 4'b0101, 0);
        emit(VLI, 1, 0, 0, 4'b1000, -1);
        emit(VST, 0, 0, 1, 4'b1111, 90);
        emit(VST, 0, 0, 2, 4'b0110, 91);
        emit(VADD, 3, 1, 1, 4'b0011, 0);
        emit(VST, 0, 0, 3, 4'b1001, 92);
        emit(VXOR, 2, 2, 1, 4'b1100, 0);
        emit(VST, 0, 0, 2, 4'b1111, 93);
        emit(HALT, 0, 0, 0, 0, 0);
        run_program("lane_mask");
    endtask

    // unaligned and negative bases, negative offset wraps to the top lines
    task automatic build_copy_program();
        emit(VLI, 15, 0, 0, 4'b1111, 264);
        emit(VLI, 14, 0, 0, 4'b1111, -16);
        emit(VLD, 1, 0, 0, 4'b1111, 70);
        emit(VST, 0, 0, 1, 4'b1111, 100);
        emit(VLD, 2, 15, 0, 4'b1111, 60);
        emit(VST, 0, 15, 2, 4'b1111, 80);
        emit(VLD, 3, 0, 0, 4'b1010, 71);
        emit(VST, 0, 0, 3, 4'b1111, 101);
        emit(VLD, 4, 14, 0, 4'b1111, 73);
        emit(VST, 0, 0, 4, 4'b1111, 102);
        emit(VLD, 5, 0, 0, 4'b1111, -3);
        emit(VST, 0, 0, 5, 4'b1111, 103);
    endtask

    task automatic load_store_test();
        prog.delete();
        build_copy_program();
        emit(HALT, 0, 0, 0, 0, 0);
        run_program("load_store");
    endtask

    task automatic control_flow_test();
        prog.delete();
        emit(VLI, 1, 0, 0, 4'b1111, 5);
        emit(VLI, 2, 0, 0, 4'b1111, 1);
        emit(VLI, 4, 0, 0, 4'b1111, 16);
        emit(VLI, 3, 0, 0, 4'b1111, 0);
        // loop head at word 4, exit to word 10
        emit(BEQZ, 0, 1, 0, 0, 6);
        emit(VST, 0, 3, 1, 4'b1111, 120);
        emit(VSUB, 1, 1, 2, 4'b1111, 0);
        emit(VADD, 3, 3, 4, 4'b1111, 0);
        emit(JMP, 0, 0, 0, 0, -4);
        emit(VST, 0, 0, 2, 4'b1111, 127);
        emit(VST, 0, 3, 3, 4'b1111, 120);
        emit(HALT, 0, 0, 0, 0, 0);
        run_program("control_flow");
    endtask

    task automatic contention_test();
        prog.delete();
        build_copy_program();
        for (int k = 0; k < 8; k++) begin
            emit(VLD, 6, 0, 0, 4'b1111, DATA_LINE + k);
            emit(VST, 0, 0, 6, 4'b1111, 110 + k);
        end
        emit(HALT, 0, 0, 0, 0, 0);
        run_program("contention");
    endtask

    initial begin
        void'($urandom(32'hbd68_7174));
        rst_n        = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        lane_arith_test();
        lane_mask_test();
        load_store_test();
        control_flow_test();
        contention_test();
        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/vcore_pkg.sv
rtl/fetch_unit.sv
rtl/decode_regfile.sv
rtl/vector_alu.sv
rtl/load_store_unit.sv
rtl/mem_arbiter.sv
rtl/vcore_top.sv
verification/mem_model.sv
verification/tb_vcore.sv

// ==== Makefile ====
# Verilator build and run for the vcore testbench

VERILATOR ?= verilator
TOP       ?= tb_vcore
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

SRCS    := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
